/* hdl/multihPkg.sv */
/*
  Shared definitions for the demodulator output and host bus logic.
  Holds the host address layout, register map codes, demod mode codes
  and the DAC source codes. Users refer to them by scoped name.
*/

package multihPkg;

  //********************
  // Host bus
  //********************
  localparam int ADDR_W = 12;  // Host address word, bit 0 always 0
  localparam int DATA_W = 16;  // Host data bus

  // Host address word, seen either raw or split into register map fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [3:0] space;   // Register block
      logic [5:0] regIdx;  // Register within block
      logic       half;    // 1 selects the upper 16 bits of a 32-bit register
      logic       zero;    // Always 0 on this bus
    } fields;
  } hostAddr_u;

  //********************
  // Register map
  //********************
  localparam logic [3:0] MISC_SPACE       = 4'd0;
  localparam logic [5:0] MISC_RESET_REG   = 6'd0;  // Write starts a soft reset
  localparam logic [5:0] MISC_VERSION_REG = 6'd1;  // Read only

  //********************
  // Demod modes
  //********************
  localparam logic [3:0] MODE_AQPSK  = 4'd3;
  localparam logic [3:0] MODE_AUQPSK = 4'd4;
  localparam logic [3:0] MODE_MULTIH = 4'd8;

  //********************
  // DAC sources
  //********************
  // Codes 8 to 11 take trellis decoder data, all others the raw input
  localparam logic [3:0] DAC_TRELLIS_I     = 4'd8;
  localparam logic [3:0] DAC_TRELLIS_Q     = 4'd9;
  localparam logic [3:0] DAC_TRELLIS_PHERR = 4'd10;
  localparam logic [3:0] DAC_TRELLIS_INDEX = 4'd11;

endpackage

/* hdl/hostRegs.sv */
/*
  Host bus register block. Decodes the address, returns the version
  word on reads and turns a write to the reset register into a
  one-cycle soft reset pulse for the reset stretcher.
*/

`timescale 1ns/1ps

module hostRegs #(
  parameter logic [multihPkg::DATA_W-1:0] VER_NUMBER = 16'h0149
) (
  input  logic                           ck933,
  input  logic                           rs_i,
  input  logic                           nCs_i,
  input  logic                           nWe_i,
  input  logic                           nRd_i,
  input  multihPkg::hostAddr_u           addr_i,
  output logic [multihPkg::DATA_W-1:0]   rdData_o,
  output logic                           softReset_o
);

  logic miscHit;
  logic resetHit;
  logic versionHit;
  logic rdEn;
  logic wrStrobe;
  logic wrDly;

  //********************
  // Address decode
  //********************
  assign miscHit    = (addr_i.fields.space == multihPkg::MISC_SPACE);
  assign resetHit   = miscHit && (addr_i.fields.regIdx == multihPkg::MISC_RESET_REG);
  assign versionHit = miscHit && (addr_i.fields.regIdx == multihPkg::MISC_VERSION_REG);

  assign rdEn     = !nCs_i && !nRd_i;
  assign wrStrobe = !nCs_i && !nWe_i;

  //********************
  // Soft reset
  //********************
  // Held high in reset so a write still open when reset ends
  // cannot fire a second pulse
  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      wrDly <= 1'b1;
    end else begin
      wrDly <= wrStrobe;
    end
  end

  assign softReset_o = wrStrobe && !wrDly && resetHit;  // First cycle of the write

  //********************
  // Read data
  //********************
  always_comb begin
    rdData_o = '0;
    if (rdEn && versionHit) begin
      if (addr_i.fields.half) begin
        rdData_o = VER_NUMBER;  // Upper half of the 32-bit register
      end
    end
  end

  // Host never drives read and write together
  busExclusive: assert property (
    @(posedge ck933) disable iff (rs_i)
    !(!nCs_i && !nWe_i && !nRd_i)
  ) else $error("Host read and write strobes active together");

endmodule

/* hdl/resetStretch.sv */
/*
  Builds the system reset from the external reset and the soft reset
  pulse. The reset is held for a fixed number of cycles after either.
*/

`timescale 1ns/1ps

module resetStretch #(
  parameter int RESET_CYCLES = 5
) (
  input  logic ck933,
  input  logic rs_i,
  input  logic softReset_i,
  output logic sysReset_o
);

  localparam int CNT_W = $clog2(RESET_CYCLES + 1);

  logic [CNT_W-1:0] holdCount;

  // Down counter keeps the reset asserted
  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      holdCount  <= CNT_W'(RESET_CYCLES);
      sysReset_o <= 1'b1;
    end else if (softReset_i) begin
      holdCount  <= CNT_W'(RESET_CYCLES - 1);  // This edge counts as the first
      sysReset_o <= 1'b1;
    end else if (holdCount != '0) begin
      holdCount  <= holdCount - 1'b1;
      sysReset_o <= 1'b1;
    end else begin
      sysReset_o <= 1'b0;
    end
  end

  // Minimum reset width seen by the rest of the design
  resetWidth: assert property (
    @(posedge ck933) $rose(sysReset_o) |-> sysReset_o [*RESET_CYCLES]
  ) else $error("System reset shorter than RESET_CYCLES");

endmodule

/* hdl/dacChannel.sv */
/*
  One DAC output channel. Picks trellis data or the raw pass-through
  word, converts it to offset binary and loads the DAC register on the
  sync enable. Instantiated once per DAC by the top level.
*/

`timescale 1ns/1ps

module dacChannel #(
  parameter int DAC_W     = 14,
  parameter int TRELLIS_W = 18
) (
  input  logic                 ck933,
  input  logic                 rs_i,
  input  logic [3:0]           demodMode_i,
  input  logic [3:0]           select_i,
  input  logic [DAC_W-1:0]     passData_i,
  input  logic [TRELLIS_W-1:0] trellisData_i,
  input  logic                 trellisSync_i,
  output logic [DAC_W-1:0]     dacD_o
);

  logic             trellisCode;
  logic             trellisPick;
  logic [DAC_W-1:0] passReg;    // Reclocked raw input
  logic [DAC_W-1:0] selData;    // Chosen source, two's complement
  logic             syncReg;    // Load enable for the output
  logic [DAC_W-1:0] offsetWord;

  //********************
  // Source select
  //********************
  always_comb begin
    case (select_i)
      multihPkg::DAC_TRELLIS_I,
      multihPkg::DAC_TRELLIS_Q,
      multihPkg::DAC_TRELLIS_PHERR,
      multihPkg::DAC_TRELLIS_INDEX: trellisCode = 1'b1;
      default:                      trellisCode = 1'b0;
    endcase
  end

  // Trellis data is only valid while the trellis demod runs
  assign trellisPick = trellisCode && (demodMode_i == multihPkg::MODE_MULTIH);

  always_ff @(posedge ck933) begin
    passReg <= passData_i;
    if (trellisPick) begin
      selData <= trellisData_i[TRELLIS_W-1 -: DAC_W];  // Keep the top bits
    end else begin
      selData <= passReg;
    end
  end

  //********************
  // Output register
  //********************
  assign offsetWord = {~selData[DAC_W-1], selData[DAC_W-2:0]};  // Offset binary

  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      syncReg <= 1'b0;
      dacD_o  <= '0;
    end else begin
      syncReg <= trellisPick ? trellisSync_i : 1'b1;  // Raw data loads every cycle
      if (syncReg) begin
        dacD_o <= offsetWord;
      end
    end
  end

  // Trellis sync low holds the output on the cycle after it is registered
  dacHold: assert property (
    @(posedge ck933) disable iff (rs_i)
    trellisPick && !trellisSync_i |=> ##1 $stable(dacD_o)
  ) else $error("DAC output changed without sync");

endmodule

/* hdl/symbolRouter.sv */
/*
  Routes decoder input symbols. Trellis decisions are taken directly in
  the trellis mode, otherwise the legacy bits pass a two stage delay.
  The two AQPSK modes carry their own Q bit and Q clock.
*/

`timescale 1ns/1ps

module symbolRouter (
  input  logic       ck933,
  input  logic       rs_i,
  input  logic [3:0] demodMode_i,
  input  logic [1:0] trellisBit_i,
  input  logic       trellisSymEn_i,
  input  logic       trellisSym2xEn_i,
  input  logic       iData_i,
  input  logic       qData_i,
  input  logic       dataSymEn_i,
  input  logic       dataSym2xEn_i,
  input  logic       auSymClk_i,
  output logic       iBit_o,
  output logic       qBit_o,
  output logic       symEn_o,
  output logic       sym2xEn_o,
  output logic       qSymEn_o
);

  logic multihMode;
  logic aqpskMode;

  // Reclock stage
  logic iIn, qIn, symEnIn, sym2xEnIn, auClkIn;
  // Legacy stage
  logic iLegacy, qLegacy, legacySymEn, legacySym2xEn;

  logic symEnNext;

  assign multihMode = (demodMode_i == multihPkg::MODE_MULTIH);
  assign aqpskMode  = (demodMode_i == multihPkg::MODE_AQPSK) ||
                      (demodMode_i == multihPkg::MODE_AUQPSK);

  //********************
  // Legacy delay line
  //********************
  always_ff @(posedge ck933) begin
    iIn           <= iData_i;
    qIn           <= qData_i;
    symEnIn       <= dataSymEn_i;
    sym2xEnIn     <= dataSym2xEn_i;
    auClkIn       <= auSymClk_i;
    iLegacy       <= iIn;
    qLegacy       <= qIn;
    legacySymEn   <= symEnIn;
    legacySym2xEn <= sym2xEnIn;
  end

  assign symEnNext = multihMode ? trellisSymEn_i : legacySymEn;

  //********************
  // Output select
  //********************
  always_ff @(posedge ck933 or posedge rs_i) begin
    if (rs_i) begin
      iBit_o    <= 1'b0;
      qBit_o    <= 1'b0;
      symEn_o   <= 1'b0;
      sym2xEn_o <= 1'b0;
      qSymEn_o  <= 1'b0;
    end else begin
      symEn_o <= symEnNext;
      if (multihMode) begin
        iBit_o    <= trellisBit_i[0];
        sym2xEn_o <= trellisSym2xEn_i;
      end else begin
        iBit_o    <= iLegacy;
        sym2xEn_o <= legacySym2xEn;
      end
      if (aqpskMode) begin
        qBit_o   <= qIn;      // Q carried on its own clock
        qSymEn_o <= auClkIn;
      end else begin
        qBit_o   <= multihMode ? trellisBit_i[1] : qLegacy;
        qSymEn_o <= symEnNext;
      end
    end
  end

endmodule

/* hdl/multihTop.sv */
/*
  Output and host bus top level of the multi-mode demodulator.
  Connects the host registers, the reset stretcher, three DAC channels
  and the symbol router, and drives read data onto the host data bus.
*/

`timescale 1ns/1ps

module multihTop #(
  parameter logic [multihPkg::DATA_W-1:0] VER_NUMBER = 16'h0149,
  parameter int RESET_CYCLES = 5,
  parameter int DAC_W        = 14,
  parameter int TRELLIS_W    = 18
) (
  input  logic                          ck933,
  input  logic                          rs_i,
  input  logic                          nCs_i,
  input  logic                          nWe_i,
  input  logic                          nRd_i,
  input  logic [multihPkg::ADDR_W-1:1]  addr_i,
  inout  wire  [multihPkg::DATA_W-1:0]  data_io,
  input  logic [3:0]                    demodMode_i,
  input  logic [3:0]                    dac0Select_i,
  input  logic [3:0]                    dac1Select_i,
  input  logic [3:0]                    dac2Select_i,
  input  logic [DAC_W-1:0]              dac0Data_i,
  input  logic [DAC_W-1:0]              dac1Data_i,
  input  logic [DAC_W-1:0]              dac2Data_i,
  input  logic [TRELLIS_W-1:0]          trellis0Data_i,
  input  logic [TRELLIS_W-1:0]          trellis1Data_i,
  input  logic [TRELLIS_W-1:0]          trellis2Data_i,
  input  logic                          trellis0Sync_i,
  input  logic                          trellis1Sync_i,
  input  logic                          trellis2Sync_i,
  input  logic [1:0]                    trellisBit_i,
  input  logic                          trellisSymEn_i,
  input  logic                          trellisSym2xEn_i,
  input  logic                          iData_i,
  input  logic                          qData_i,
  input  logic                          dataSymEn_i,
  input  logic                          dataSym2xEn_i,
  input  logic                          auSymClk_i,
  output logic [DAC_W-1:0]              dac0D_o,
  output logic [DAC_W-1:0]              dac1D_o,
  output logic [DAC_W-1:0]              dac2D_o,
  output logic                          iBit_o,
  output logic                          qBit_o,
  output logic                          symEn_o,
  output logic                          sym2xEn_o,
  output logic                          qSymEn_o
);

  localparam int NUM_DAC = 3;

  multihPkg::hostAddr_u          hostAddr;
  logic [multihPkg::DATA_W-1:0]  rdData;
  logic                          softReset;
  logic                          sysReset;

  logic [3:0]           dacSelect [NUM_DAC];
  logic [DAC_W-1:0]     dacIn     [NUM_DAC];
  logic [TRELLIS_W-1:0] trellisIn [NUM_DAC];
  logic                 syncIn    [NUM_DAC];
  logic [DAC_W-1:0]     dacOut    [NUM_DAC];

  assign hostAddr.raw = {addr_i, 1'b0};  // Byte bit is not on the pads

  //********************
  // Host bus and reset
  //********************
  hostRegs #(.VER_NUMBER(VER_NUMBER)) uHostRegs (
    .ck933       (ck933),
    .rs_i        (sysReset),
    .nCs_i       (nCs_i),
    .nWe_i       (nWe_i),
    .nRd_i       (nRd_i),
    .addr_i      (hostAddr),
    .rdData_o    (rdData),
    .softReset_o (softReset)
  );

  resetStretch #(.RESET_CYCLES(RESET_CYCLES)) uResetStretch (
    .ck933       (ck933),
    .rs_i        (rs_i),
    .softReset_i (softReset),
    .sysReset_o  (sysReset)
  );

  // Read data only while the host reads
  assign data_io = (!nCs_i && !nRd_i) ? rdData : 'z;

  //********************
  // DAC channels
  //********************
  assign dacSelect = '{dac0Select_i, dac1Select_i, dac2Select_i};
  assign dacIn     = '{dac0Data_i, dac1Data_i, dac2Data_i};
  assign trellisIn = '{trellis0Data_i, trellis1Data_i, trellis2Data_i};
  assign syncIn    = '{trellis0Sync_i, trellis1Sync_i, trellis2Sync_i};

  for (genvar ch = 0; ch < NUM_DAC; ch++) begin : gDac
    dacChannel #(.DAC_W(DAC_W), .TRELLIS_W(TRELLIS_W)) uDac (
      .ck933         (ck933),
      .rs_i          (sysReset),
      .demodMode_i   (demodMode_i),
      .select_i      (dacSelect[ch]),
      .passData_i    (dacIn[ch]),
      .trellisData_i (trellisIn[ch]),
      .trellisSync_i (syncIn[ch]),
      .dacD_o        (dacOut[ch])
    );
  end

  assign dac0D_o = dacOut[0];
  assign dac1D_o = dacOut[1];
  assign dac2D_o = dacOut[2];

  //********************
  // Symbol routing
  //********************
  symbolRouter uSymbolRouter (
    .ck933            (ck933),
    .rs_i             (sysReset),
    .demodMode_i      (demodMode_i),
    .trellisBit_i     (trellisBit_i),
    .trellisSymEn_i   (trellisSymEn_i),
    .trellisSym2xEn_i (trellisSym2xEn_i),
    .iData_i          (iData_i),
    .qData_i          (qData_i),
    .dataSymEn_i      (dataSymEn_i),
    .dataSym2xEn_i    (dataSym2xEn_i),
    .auSymClk_i       (auSymClk_i),
    .iBit_o           (iBit_o),
    .qBit_o           (qBit_o),
    .symEn_o          (symEn_o),
    .sym2xEn_o        (sym2xEn_o),
    .qSymEn_o         (qSymEn_o)
  );

endmodule

/* test/multihTbChecks.svh */
/*
  Reference model and compare tasks for the top level testbench.
  Included inside the testbench module after its failure task.
*/

`ifndef MULTIH_TB_CHECKS_SVH
`define MULTIH_TB_CHECKS_SVH

// Inputs as sampled on one rising edge
typedef struct packed {
  logic                              rstBefore;  // System reset before the edge
  logic                              rstNow;     // System reset after the edge
  logic [3:0]                        mode;
  logic [NUM_DAC-1:0][3:0]           sel;
  logic [NUM_DAC-1:0][DAC_W-1:0]     pass;
  logic [NUM_DAC-1:0][TRELLIS_W-1:0] trellis;
  logic [NUM_DAC-1:0]                sync;
  logic [1:0]                        tBit;
  logic                              tSymEn;
  logic                              tSym2xEn;
  logic                              iData;
  logic                              qData;
  logic                              dSymEn;
  logic                              dSym2xEn;
  logic                              auClk;
} edgeSample_t;

edgeSample_t hist[$];  // Newest first, three deep

//********************
// Reference functions
//********************
function automatic logic isTrellisSel(input logic [3:0] sel);
  return (sel == multihPkg::DAC_TRELLIS_I) || (sel == multihPkg::DAC_TRELLIS_Q) ||
         (sel == multihPkg::DAC_TRELLIS_PHERR) || (sel == multihPkg::DAC_TRELLIS_INDEX);
endfunction

function automatic logic [DAC_W-1:0] offsetBinary(input logic [DAC_W-1:0] word);
  return word + {1'b1, {(DAC_W-1){1'b0}}};  // Add half scale
endfunction

// Trellis words load 2 cycles on, raw words 3 cycles on
function automatic logic [DAC_W-1:0] nextDac(input int ch, input logic [DAC_W-1:0] held);
  edgeSample_t now;
  edgeSample_t prev;
  edgeSample_t old;
  logic        pick;
  now = hist[0];
  if (now.rstBefore || now.rstNow) begin
    return '0;
  end
  prev = hist[1];
  old  = hist[2];
  pick = isTrellisSel(prev.sel[ch]) && (prev.mode == multihPkg::MODE_MULTIH);
  if (prev.rstBefore || (pick && !prev.sync[ch])) begin
    return held;  // No load enable
  end
  if (pick) begin
    return offsetBinary(DAC_W'(prev.trellis[ch] >> (TRELLIS_W - DAC_W)));
  end
  return offsetBinary(old.pass[ch]);
endfunction

// Packed as i, q, symEn, sym2xEn, qSymEn
function automatic logic [4:0] expectedSymbols();
  edgeSample_t now;
  edgeSample_t prev;
  edgeSample_t old;
  logic        i;
  logic        q;
  logic        en;
  logic        en2;
  logic        qEn;
  now = hist[0];
  if (now.rstBefore || now.rstNow) begin
    return '0;
  end
  prev = hist[1];
  old  = hist[2];
  if (now.mode == multihPkg::MODE_MULTIH) begin
    i   = now.tBit[0];
    q   = now.tBit[1];
    en  = now.tSymEn;
    en2 = now.tSym2xEn;
  end else begin
    i   = old.iData;  // Legacy path
    q   = old.qData;
    en  = old.dSymEn;
    en2 = old.dSym2xEn;
  end
  qEn = en;
  if ((now.mode == multihPkg::MODE_AQPSK) || (now.mode == multihPkg::MODE_AUQPSK)) begin
    q   = prev.qData;
    qEn = prev.auClk;
  end
  return {i, q, en, en2, qEn};
endfunction

function automatic logic [11:1] hostAddrOf(input logic [3:0] space, input logic [5:0] regIdx,
                                           input logic half);
  return {space, regIdx, half};
endfunction

function automatic logic [15:0] expectedRead(input logic [11:1] addr);
  if ((addr[11:8] == multihPkg::MISC_SPACE) && (addr[7:2] == multihPkg::MISC_VERSION_REG) &&
      addr[1]) begin
    return VER_NUMBER;
  end
  return '0;
endfunction

//********************
// Compare tasks
//********************
task automatic checkDacWord(input string name, input logic [DAC_W-1:0] expWord,
                            input logic [DAC_W-1:0] gotWord);
  if (gotWord !== expWord) begin
    failRun($sformatf("ERROR %s: expected %h, got %h at %0t ns", name, expWord, gotWord,
                      $time));
  end
endtask

task automatic checkSymBit(input string name, input logic expBit, input logic gotBit);
  if (gotBit !== expBit) begin
    failRun($sformatf("ERROR %s: expected %h, got %h at %0t ns", name, expBit, gotBit, $time));
  end
endtask

task automatic checkHostWord(input string name, input logic [15:0] expWord,
                             input logic [15:0] gotWord);
  if (gotWord !== expWord) begin
    failRun($sformatf("ERROR %s: expected %h, got %h at %0t ns", name, expWord, gotWord,
                      $time));
  end
endtask

`endif

/* test/multihTb.sv */
/*
  Testbench for the demodulator output and host bus top level.
  Runs random DAC, trellis and symbol traffic through each mode, reads
  the version register, issues a soft reset and checks every cycle.
*/

`timescale 1ns/1ps

module multihTb;

  localparam logic [15:0] VER_NUMBER = 16'h0149;
  localparam int RESET_CYCLES = 5;
  localparam int DAC_W        = 14;
  localparam int TRELLIS_W    = 18;
  localparam int NUM_DAC      = 3;

  // Test lengths in clock cycles
  localparam int PASS_CYC    = 200;
  localparam int TREL_CYC    = 200;
  localparam int AQ_CYC      = 80;
  localparam int SOFT_CYC    = 60;
  localparam int TEST_CYC    = 2 + RESET_CYCLES + 4 + 4 * 3 + 2 + PASS_CYC + TREL_CYC +
                               2 * AQ_CYC + SOFT_CYC;
  localparam int TIMEOUT_CYC = TEST_CYC * 3 / 2;

  logic                 ck933;
  logic                 rs;
  logic                 nCs;
  logic                 nWe;
  logic                 nRd;
  logic [11:1]          hostAddr;
  logic                 hostDrive;   // Host owns the data bus
  logic [15:0]          hostWrData;
  wire  [15:0]          dataBus;
  logic [3:0]           demodMode;
  logic [3:0]           dacSel      [NUM_DAC];
  logic [DAC_W-1:0]     dacData     [NUM_DAC];
  logic [TRELLIS_W-1:0] trellisData [NUM_DAC];
  logic                 trellisSync [NUM_DAC];
  logic [1:0]           trellisBit;
  logic                 trellisSymEn;
  logic                 trellisSym2xEn;
  logic                 iData;
  logic                 qData;
  logic                 dataSymEn;
  logic                 dataSym2xEn;
  logic                 auSymClk;
  wire  [DAC_W-1:0]     dac0D;
  wire  [DAC_W-1:0]     dac1D;
  wire  [DAC_W-1:0]     dac2D;
  wire                  iBit;
  wire                  qBit;
  wire                  symEn;
  wire                  sym2xEn;
  wire                  qSymEn;

  // Reference model state
  logic [DAC_W-1:0]     expDac [NUM_DAC];
  logic [4:0]           expSym;       // i, q, symEn, sym2xEn, qSymEn
  logic                 expRst;       // Expected system reset
  logic                 wrPrev;
  int                   sinceRs;
  int                   sinceSoft;
  int                   cycleCount;
  int                   errorCount;
  integer               seed;

  task automatic failRun(input string why);
    errorCount++;
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  `include "multihTbChecks.svh"

  assign dataBus = hostDrive ? hostWrData : 'z;

  multihTop #(
    .VER_NUMBER(VER_NUMBER), .RESET_CYCLES(RESET_CYCLES),
    .DAC_W(DAC_W), .TRELLIS_W(TRELLIS_W)
  ) uut (
    .ck933(ck933), .rs_i(rs), .nCs_i(nCs), .nWe_i(nWe), .nRd_i(nRd),
    .addr_i(hostAddr), .data_io(dataBus), .demodMode_i(demodMode),
    .dac0Select_i(dacSel[0]), .dac1Select_i(dacSel[1]), .dac2Select_i(dacSel[2]),
    .dac0Data_i(dacData[0]), .dac1Data_i(dacData[1]), .dac2Data_i(dacData[2]),
    .trellis0Data_i(trellisData[0]), .trellis1Data_i(trellisData[1]),
    .trellis2Data_i(trellisData[2]), .trellis0Sync_i(trellisSync[0]),
    .trellis1Sync_i(trellisSync[1]), .trellis2Sync_i(trellisSync[2]),
    .trellisBit_i(trellisBit), .trellisSymEn_i(trellisSymEn),
    .trellisSym2xEn_i(trellisSym2xEn), .iData_i(iData), .qData_i(qData),
    .dataSymEn_i(dataSymEn), .dataSym2xEn_i(dataSym2xEn), .auSymClk_i(auSymClk),
    .dac0D_o(dac0D), .dac1D_o(dac1D), .dac2D_o(dac2D), .iBit_o(iBit),
    .qBit_o(qBit), .symEn_o(symEn), .sym2xEn_o(sym2xEn), .qSymEn_o(qSymEn)
  );

  initial begin
    ck933 = 1'b0;
    forever #4 ck933 = ~ck933;
  end

  //********************
  // Reference and compare
  //********************
  always @(posedge ck933) begin : referenceModel
    edgeSample_t s;
    logic wrNow;
    logic softNow;
    int   ch;
    wrNow   = !nCs && !nWe;
    softNow = wrNow && !wrPrev && (hostAddr[11:8] == multihPkg::MISC_SPACE) &&
              (hostAddr[7:2] == multihPkg::MISC_RESET_REG);  // First cycle only
    s.rstBefore = expRst;
    sinceRs   = rs ? 0 : sinceRs + 1;
    sinceSoft = softNow ? 0 : sinceSoft + 1;
    expRst    = (sinceRs <= RESET_CYCLES) || (sinceSoft < RESET_CYCLES);
    wrPrev    = wrNow;
    s.rstNow  = expRst;
    s.mode    = demodMode;
    for (ch = 0; ch < NUM_DAC; ch++) begin
      s.sel[ch]     = dacSel[ch];
      s.pass[ch]    = dacData[ch];
      s.trellis[ch] = trellisData[ch];
      s.sync[ch]    = trellisSync[ch];
    end
    s.tBit     = trellisBit;
    s.tSymEn   = trellisSymEn;
    s.tSym2xEn = trellisSym2xEn;
    s.iData    = iData;
    s.qData    = qData;
    s.dSymEn   = dataSymEn;
    s.dSym2xEn = dataSym2xEn;
    s.auClk    = auSymClk;
    hist.push_front(s);
    if (hist.size() > 3) begin
      hist.delete(3);
    end
    for (ch = 0; ch < NUM_DAC; ch++) begin
      expDac[ch] = nextDac(ch, expDac[ch]);
    end
    expSym = expectedSymbols();
  end

  always @(negedge ck933) begin : compareOutputs
    if (hist.size() > 0) begin
      checkDacWord("dac0D_o", expDac[0], dac0D);
      checkDacWord("dac1D_o", expDac[1], dac1D);
      checkDacWord("dac2D_o", expDac[2], dac2D);
      checkSymBit("iBit_o", expSym[4], iBit);
      checkSymBit("qBit_o", expSym[3], qBit);
      checkSymBit("symEn_o", expSym[2], symEn);
      checkSymBit("sym2xEn_o", expSym[1], sym2xEn);
      checkSymBit("qSymEn_o", expSym[0], qSymEn);
    end
  end

  initial begin : watchdog
    cycleCount = 0;
    while (cycleCount < TIMEOUT_CYC) begin
      @(posedge ck933);
      cycleCount++;
    end
    failRun("Timeout, the run did not finish within the cycle limit");
  end

  //********************
  // Stimulus
  //********************
  task automatic randomCycle();
    int ch;
    @(negedge ck933);
    for (ch = 0; ch < NUM_DAC; ch++) begin
      dacData[ch]     = $random(seed);
      trellisData[ch] = $random(seed);
      trellisSync[ch] = $random(seed);  // Random sync pattern
    end
    trellisBit     = $random(seed);
    trellisSymEn   = $random(seed);
    trellisSym2xEn = $random(seed);
    iData          = $random(seed);
    qData          = $random(seed);
    dataSymEn      = $random(seed);
    dataSym2xEn    = $random(seed);
    auSymClk       = $random(seed);
  endtask

  task automatic runCycles(input int n);
    repeat (n) randomCycle();
  endtask

  // Called at a falling edge
  task automatic setRoute(input logic [3:0] mode, input logic [3:0] s0,
                          input logic [3:0] s1, input logic [3:0] s2);
    demodMode = mode;
    dacSel[0] = s0;
    dacSel[1] = s1;
    dacSel[2] = s2;
  endtask

  task automatic hostRead(input logic [11:1] addr);
    @(negedge ck933);
    hostAddr = addr;
    nCs      = 1'b0;
    nRd      = 1'b0;
    @(posedge ck933);
    checkHostWord("data_io", expectedRead(addr), dataBus);
    @(negedge ck933);
    nCs = 1'b1;
    nRd = 1'b1;
    @(posedge ck933);
    checkHostWord("data_io", 16'hzzzz, dataBus);  // Bus released
    @(negedge ck933);
  endtask

  task automatic hostWrite(input logic [11:1] addr, input logic [15:0] word);
    @(negedge ck933);
    hostAddr   = addr;
    hostWrData = word;
    hostDrive  = 1'b1;
    nCs        = 1'b0;
    nWe        = 1'b0;
    @(negedge ck933);
    nCs       = 1'b1;
    nWe       = 1'b1;
    hostDrive = 1'b0;
  endtask

  initial begin : stimulus
    int ch;
    seed       = 9;
    errorCount = 0;
    expRst     = 1'b1;
    wrPrev     = 1'b0;
    sinceRs    = 0;
    sinceSoft  = RESET_CYCLES + 1;
    expSym     = '0;
    rs         = 1'b1;
    nCs        = 1'b1;
    nWe        = 1'b1;
    nRd        = 1'b1;
    hostAddr   = '0;
    hostDrive  = 1'b0;
    hostWrData = '0;
    demodMode  = '0;
    for (ch = 0; ch < NUM_DAC; ch++) begin
      expDac[ch]      = '0;
      dacSel[ch]      = '0;
      dacData[ch]     = '0;
      trellisData[ch] = '0;
      trellisSync[ch] = 1'b0;
    end
    trellisBit     = '0;
    trellisSymEn   = 1'b0;
    trellisSym2xEn = 1'b0;
    iData          = 1'b0;
    qData          = 1'b0;
    dataSymEn      = 1'b0;
    dataSym2xEn    = 1'b0;
    auSymClk       = 1'b0;

    repeat (2) @(posedge ck933);
    @(negedge ck933);
    rs = 1'b0;
    runCycles(RESET_CYCLES + 4);

    hostRead(hostAddrOf(multihPkg::MISC_SPACE, multihPkg::MISC_VERSION_REG, 1'b1));
    hostRead(hostAddrOf(multihPkg::MISC_SPACE, multihPkg::MISC_VERSION_REG, 1'b0));
    hostRead(hostAddrOf(4'd5, multihPkg::MISC_VERSION_REG, 1'b1));  // Outside MISC
    hostRead(hostAddrOf(multihPkg::MISC_SPACE, multihPkg::MISC_RESET_REG, 1'b1));

    // Raw data, also trellis codes outside the trellis mode
    setRoute(multihPkg::MODE_MULTIH, 4'd0, 4'd1, 4'd7);
    runCycles(PASS_CYC / 2);
    setRoute(4'd0, multihPkg::DAC_TRELLIS_I, multihPkg::DAC_TRELLIS_Q,
             multihPkg::DAC_TRELLIS_INDEX);
    runCycles(PASS_CYC / 2);

    setRoute(multihPkg::MODE_MULTIH, multihPkg::DAC_TRELLIS_I, multihPkg::DAC_TRELLIS_Q,
             multihPkg::DAC_TRELLIS_PHERR);
    runCycles(TREL_CYC / 2);
    setRoute(multihPkg::MODE_MULTIH, multihPkg::DAC_TRELLIS_INDEX, 4'd2,
             multihPkg::DAC_TRELLIS_I);
    runCycles(TREL_CYC / 2);

    setRoute(multihPkg::MODE_AQPSK, 4'd0, 4'd0, 4'd0);
    runCycles(AQ_CYC);
    setRoute(multihPkg::MODE_AUQPSK, 4'd4, 4'd5, 4'd6);
    runCycles(AQ_CYC);

    hostWrite(hostAddrOf(multihPkg::MISC_SPACE, multihPkg::MISC_RESET_REG, 1'b0), 16'h0001);
    setRoute(4'd1, 4'd3, 4'd4, 4'd5);
    runCycles(SOFT_CYC);

    if (errorCount == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+test
hdl/multihPkg.sv
hdl/hostRegs.sv
hdl/resetStretch.sv
hdl/dacChannel.sv
hdl/symbolRouter.sv
hdl/multihTop.sv
test/multihTb.sv

/* Bender.yml */
package:
  name: multih

sources:
  - files:
      - hdl/multihPkg.sv
      - hdl/hostRegs.sv
      - hdl/resetStretch.sv
      - hdl/dacChannel.sv
      - hdl/symbolRouter.sv
      - hdl/multihTop.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/multihTb.sv
